// ==== run_sim.sh ====
#!/bin/sh
# Build and run the systolic array testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_top -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
fi
exit 1

// ==== src.f ====
verilog/sa_pkg.sv
verilog/fp_mul.sv
verilog/fp_add.sv
verilog/pe_cell.sv
verilog/act_skew_feeder.sv
verilog/psum_drain.sv
verilog/systolic_mm_top.sv
verification/sa_properties.sv
verification/sa_checker.sv
verification/tb_top.sv

// ==== verification/sa_checker.sv ====
module sa_checker #(
    parameter int N = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             load_i,
    input  logic             start_i,
    input  logic             done_i,
    input  sa_pkg::fp_word_u c_i [N*N],     // DUT result
    input  sa_pkg::fp_word_u exp_i [N*N],   // Expected result
    input  int               test_i,
    output int               errors_o = 0,
    output int               tests_o = 0
);
    timeunit 1ns;
    timeprecision 1ps;
    import sa_pkg::*;

    int   steps  = 0;       // Start-high cycles since load
    int   bad    = 0;       // Errors in the current test
    logic done_q = 1'b0;
    logic idle_seen = 1'b0; // Idle check after reset done

    always @(posedge clk) begin
        if (!reset) begin
            steps  = 0;
            done_q = 1'b0;
        end else if (!idle_seen) begin
            bad = 0;
            if (done_i !== 1'b0) begin
                $display("[FAIL] %0t done_o got %b expected 0", $time, done_i);
                bad++;
            end
            for (int k = 0; k < N * N; k++) begin
                if (c_i[k].raw !== '0) begin
                    $display("[FAIL] %0t c_o[%0d] got %h expected 0000", $time, k, c_i[k].raw);
                    bad++;
                end
            end
            $display("test %0d (idle after reset): %s", test_i, (bad == 0) ? "ok" : "bad");
            errors_o += bad;
            tests_o++;
            idle_seen = 1'b1;
            done_q = done_i;
        end else begin
            if (done_i && !done_q) begin        // done_o rose on the previous edge
                bad = 0;
                if (steps != 3 * N) begin
                    $display("done_o came after %0d compute cycles instead of %0d at %0t",
                             steps, 3 * N, $time);
                    bad++;
                end
                for (int k = 0; k < N * N; k++) begin
                    if (c_i[k].raw !== exp_i[k].raw) begin
                        $display("[FAIL] %0t c_o[%0d] got %h expected %h",
                                 $time, k, c_i[k].raw, exp_i[k].raw);
                        bad++;
                    end
                end
                $display("test %0d: %s, %0d errors", test_i, (bad == 0) ? "ok" : "bad", bad);
                errors_o += bad;
                tests_o++;
            end
            if (load_i) steps = 0;
            else if (start_i && !done_i) steps++;
            done_q = done_i;
        end
    end

endmodule

// ==== verification/sa_properties.sv ====
module sa_properties #(
    parameter int N = 2
) (
    input logic             clk,
    input logic             reset,
    input logic             load_i,
    input logic             start_i,
    input logic             done_o,
    input sa_pkg::fp_word_u c_o [N*N]
);
    timeunit 1ns;
    timeprecision 1ps;
    import sa_pkg::*;

    logic [N*N*DATA_W-1:0] c_flat;          // Whole result as one vector
    int                    fails = 0;       // Assertion failures so far

    always_comb begin
        for (int k = 0; k < N * N; k++) begin
            c_flat[k*DATA_W +: DATA_W] = c_o[k].raw;
        end
    end

    a_load_clears: assert property (@(posedge clk) disable iff (!reset)
        load_i |=> !done_o) else begin
        $error("done_o high after load_i");
        fails++;
    end

    a_result_holds: assert property (@(posedge clk) disable iff (!reset)
        (done_o && !load_i) |=> $stable(c_flat)) else begin
        $error("c_o changed while done");
        fails++;
    end

    a_done_needs_start: assert property (@(posedge clk) disable iff (!reset)
        $rose(done_o) |-> $past(start_i)) else begin
        $error("done_o rose without start_i");
        fails++;
    end

endmodule

bind systolic_mm_top sa_properties #(.N(N)) u_props (
    .clk(clk), .reset(reset), .load_i(load_i), .start_i(start_i),
    .done_o(done_o), .c_o(c_o)
);

// ==== verification/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import sa_pkg::*;

    localparam int N         = 2;
    localparam int NUM_TESTS = 16;                  // Array jobs without the idle check
    localparam int MAX_PAUSE = 5;                   // Longest start_i gap in cycles
    localparam int LIMIT     = NUM_TESTS * (3 * N + 8 + MAX_PAUSE) + 50;

    logic     clk = 1'b0;
    logic     reset;
    logic     load;
    logic     start;
    fp_word_u a [N*N];
    fp_word_u b [N*N];
    fp_word_u c [N*N];
    fp_word_u exp_c [N*N];                          // Expected result for the checker
    logic     done;
    int       test_no;
    int       errors;
    int       tests;
    int       cycles = 0;

    always #10 clk = ~clk;                          // 20 ns period

    systolic_mm_top #(.N(N)) UUT (
        .clk(clk), .reset(reset), .load_i(load), .start_i(start),
        .a_i(a), .b_i(b), .c_o(c), .done_o(done)
    );

    sa_checker #(.N(N)) u_checker (
        .clk(clk), .reset(reset), .load_i(load), .start_i(start), .done_i(done),
        .c_i(c), .exp_i(exp_c), .test_i(test_no), .errors_o(errors), .tests_o(tests)
    );

    // Truncating multiply from the format rules
    function automatic fp_word_u ref_mul(fp_word_u x, fp_word_u y);
        fp_word_u p;
        int       prod;
        int       e;
        p.raw = '0;
        if (x.fields.exp == 0 || y.fields.exp == 0) return p;   // Zero exponent kills it
        prod = (128 + int'(x.fields.man)) * (128 + int'(y.fields.man));
        e    = int'(x.fields.exp) + int'(y.fields.exp) - EXP_BIAS;
        if (prod >= (1 << 15)) begin
            prod = prod >> 8;                       // Product of 2.0 or more shifts one further
            e    = e + 1;
        end else begin
            prod = prod >> 7;
        end
        p.fields.sign = x.fields.sign ^ y.fields.sign;
        if (e < 1 || e > EXP_MAX) begin
            p.fields.exp = '1;                      // Out of range
            p.fields.man = '0;
        end else begin
            p.fields.exp = e[EXP_W-1:0];
            p.fields.man = prod[MAN_W-1:0];
        end
        return p;
    endfunction

    // Same-sign add with zero pass-through and zero for the rest
    function automatic fp_word_u ref_add(fp_word_u x, fp_word_u y);
        fp_word_u s;
        fp_word_u hi;
        fp_word_u lo;
        int       mh;
        s.raw = '0;
        if ((&x.fields.exp) || (&y.fields.exp)) return s;
        if (x.raw == 0) return y;
        if (y.raw == 0) return x;
        if (x.fields.sign != y.fields.sign) return s;
        hi = (x.raw[DATA_W-2:0] >= y.raw[DATA_W-2:0]) ? x : y;
        lo = (x.raw[DATA_W-2:0] >= y.raw[DATA_W-2:0]) ? y : x;
        mh = (128 + int'(hi.fields.man))
           + ((128 + int'(lo.fields.man)) >> (int'(hi.fields.exp) - int'(lo.fields.exp)));
        s.fields.sign = hi.fields.sign;
        if (mh >= 256) begin                        // Carry renormalizes
            s.fields.exp = hi.fields.exp + 1'b1;
            s.fields.man = mh[MAN_W:1];
        end else begin
            s.fields.exp = hi.fields.exp;
            s.fields.man = mh[MAN_W-1:0];
        end
        return s;
    endfunction

    // C = A x B with rows of B accumulated in order 0..N-1
    function automatic void compute_expected();
        fp_word_u acc;
        for (int m = 0; m < N; m++) begin
            for (int k = 0; k < N; k++) begin
                acc.raw = '0;
                for (int r = 0; r < N; r++) begin
                    acc = ref_add(acc, ref_mul(a[m*N+r], b[r*N+k]));
                end
                exp_c[m*N+k] = acc;
            end
        end
    endfunction

    function automatic fp_word_u rand_word();
        fp_word_u w;
        w.fields.sign = 1'b0;
        w.fields.exp  = EXP_W'(120 + $urandom % 15);    // 120 to 134
        w.fields.man  = MAN_W'($urandom % 128);
        return w;
    endfunction

    function automatic void fill_random();
        for (int k = 0; k < N * N; k++) begin
            a[k] = rand_word();
            b[k] = rand_word();
        end
    endfunction

    // One job of load and compute with an optional gap in start_i until done
    task automatic run_job(input int pause_at, input int pause_len);
        compute_expected();
        @(posedge clk);
        #2 load = 1'b1;
        start = 1'b0;
        test_no = test_no + 1;
        @(posedge clk);
        #2 load = 1'b0;
        start = 1'b1;
        if (pause_len > 0) begin
            repeat (pause_at) @(posedge clk);
            #2 start = 1'b0;
            repeat (pause_len) @(posedge clk);
            #2 start = 1'b1;
        end
        do begin
            @(posedge clk);
            #2;
        end while (!done);
        @(posedge clk);                             // Checker sees the rise here
        #2 start = 1'b0;
    endtask

    // Cycle limit from the number and length of the jobs
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: done_o did not arrive within %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(57));
        reset   = 1'b0;
        load    = 1'b0;
        start   = 1'b0;
        test_no = 1;                                // Test 1 is the idle check after reset
        for (int k = 0; k < N * N; k++) begin
            a[k].raw = '0;
            b[k].raw = '0;
            exp_c[k].raw = '0;
        end
        repeat (10) @(posedge clk);
        #2 reset = 1'b1;

        // Exact powers of two
        for (int m = 0; m < N; m++) begin
            for (int k = 0; k < N; k++) begin
                a[m*N+k].raw = '0;
                a[m*N+k].fields.exp = EXP_W'(EXP_BIAS + m);
                b[m*N+k].raw = '0;
                b[m*N+k].fields.exp = EXP_W'(EXP_BIAS + k);
            end
        end
        run_job(0, 0);

        // Random positive pairs
        repeat (10) begin
            fill_random();
            run_job(0, 0);
        end

        // Gaps in start_i mid-compute
        repeat (3) begin
            fill_random();
            run_job(1 + $urandom % (3 * N - 1), 1 + $urandom % MAX_PAUSE);
        end

        // Zero exponents
        fill_random();
        a[0].fields.exp = '0;
        b[N*N-1].fields.exp = '0;
        run_job(0, 0);

        // Opposite-sign products in row 0 cancel to zero
        fill_random();
        a[1].fields.sign = 1'b1;
        run_job(0, 0);

        repeat (2) @(posedge clk);
        if (tests != NUM_TESTS + 1) begin
            $display("The checker finished %0d tests but %0d were run", tests, NUM_TESTS + 1);
        end
        if (UUT.u_props.fails != 0) begin
            $display("Assertions on the DUT failed %0d times", UUT.u_props.fails);
        end
        $display("Tests run: %0d, errors: %0d, assertion failures: %0d",
                 tests, errors, UUT.u_props.fails);
        if (errors == 0 && tests == NUM_TESTS + 1 && UUT.u_props.fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog/act_skew_feeder.sv ====
module act_skew_feeder #(
    parameter int N = 2                     // Array dimension
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             load_i,
    input  logic             start_i,
    input  sa_pkg::fp_word_u a_i [N*N],     // Matrix A, row-major
    output sa_pkg::fp_word_u west_o [N]     // One activation per array row
);
    import sa_pkg::*;

    localparam int LEN = 2 * N - 1;         // Room for N words plus N-1 skew slots

    // Row r carries column r of A, skewed r places toward the tail
    fp_word_u line [N][LEN];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < N; r++) begin
                for (int k = 0; k < LEN; k++) begin
                    line[r][k] <= '0;
                end
            end
        end else if (load_i) begin
            for (int r = 0; r < N; r++) begin
                for (int k = 0; k < LEN; k++) begin
                    line[r][k] <= '0;       // Skew slots stay zero
                end
                for (int m = 0; m < N; m++) begin
                    line[r][m+r] <= a_i[m*N+r];  // A[m][r] at m+r, later write wins
                end
            end
        end else if (start_i) begin
            for (int r = 0; r < N; r++) begin
                for (int k = 0; k < LEN - 1; k++) begin
                    line[r][k] <= line[r][k+1];  // Move toward the array
                end
                line[r][LEN-1] <= '0;       // Zeros fill in behind
            end
        end
    end

    // Head of each line drives its row
    always_comb begin
        for (int r = 0; r < N; r++) begin
            west_o[r] = line[r][0];
        end
    end

endmodule

// ==== verilog/fp_add.sv ====
module fp_add (
    input  sa_pkg::fp_word_u a_i,  // Partial sum from the north
    input  sa_pkg::fp_word_u b_i,  // Product of this cell
    output sa_pkg::fp_word_u s_o
);
    import sa_pkg::*;

    logic             a_big;     // a_i magnitude not below b_i
    fp_word_u         op_hi;     // Larger magnitude operand
    fp_word_u         op_lo;
    logic [EXP_W-1:0] diff;      // Alignment distance
    logic [MAN_W:0]   lo_align;  // Smaller mantissa after right shift
    logic [MAN_W+1:0] sum;       // Carry, hidden bit, fraction

    always_comb begin
        // Magnitude compare on raw bits below the sign
        a_big = a_i.raw[DATA_W-2:0] >= b_i.raw[DATA_W-2:0];
        op_hi = a_big ? a_i : b_i;
        op_lo = a_big ? b_i : a_i;

        diff     = op_hi.fields.exp - op_lo.fields.exp;
        lo_align = {1'b1, op_lo.fields.man} >> diff;   // Shifted-out bits are lost
        sum      = {1'b0, 1'b1, op_hi.fields.man} + {1'b0, lo_align};

        if ((&a_i.fields.exp) || (&b_i.fields.exp)) begin
            s_o.raw = '0;                              // Inf or NaN operand
        end else if (a_i.raw == '0) begin
            s_o = b_i;                                 // Exact pass-through
        end else if (b_i.raw == '0) begin
            s_o = a_i;
        end else if (a_i.fields.sign != b_i.fields.sign) begin
            s_o.raw = '0;                              // No subtract path
        end else begin
            s_o.fields.sign = op_hi.fields.sign;
            if (sum[MAN_W+1]) begin                    // Carry out, renormalize
                s_o.fields.exp = op_hi.fields.exp + 1'b1;
                s_o.fields.man = sum[MAN_W:1];
            end else begin
                s_o.fields.exp = op_hi.fields.exp;
                s_o.fields.man = sum[MAN_W-1:0];
            end
        end
    end

endmodule

// ==== verilog/fp_mul.sv ====
module fp_mul (
    input  sa_pkg::fp_word_u a_i,  // Activation
    input  sa_pkg::fp_word_u b_i,  // Stationary weight
    output sa_pkg::fp_word_u p_o   // Truncated product
);
    import sa_pkg::*;

    localparam int PROD_W = 2 * (MAN_W + 1);  // Hidden-bit product width

    logic [PROD_W-1:0] prod;       // Raw mantissa product, 1.0 to just under 4.0
    logic              top;        // Product at or above 2.0
    logic [MAN_W-1:0]  man;        // Normalized, truncated fraction
    logic [EXP_W+1:0]  e_sum;      // Exponent sum, still biased twice
    logic              sign;
    logic              zero;       // Either operand has zero exponent
    logic              out_range;  // Result exponent not representable

    always_comb begin
        prod = {1'b1, a_i.fields.man} * {1'b1, b_i.fields.man};
        top  = prod[PROD_W-1];

        // Normalize on the top bit and drop the rest, no rounding
        man = top ? prod[PROD_W-2 -: MAN_W] : prod[PROD_W-3 -: MAN_W];

        // Normalizing shift bumps the exponent by one
        e_sum = (EXP_W+2)'(a_i.fields.exp) + (EXP_W+2)'(b_i.fields.exp)
              + (EXP_W+2)'(top);

        sign = a_i.fields.sign ^ b_i.fields.sign;
        zero = (a_i.fields.exp == '0) || (b_i.fields.exp == '0);

        // After removing one bias the exponent must land in 1..EXP_MAX
        out_range = (e_sum <= (EXP_W+2)'(EXP_BIAS))
                 || (e_sum > (EXP_W+2)'(EXP_MAX + EXP_BIAS));

        if (zero) begin
            p_o.raw = '0;                   // Plain zero, sign dropped too
        end else if (out_range) begin
            p_o.fields.sign = sign;
            p_o.fields.exp  = '1;           // Overflow and underflow share this pattern
            p_o.fields.man  = '0;
        end else begin
            p_o.fields.sign = sign;
            p_o.fields.exp  = EXP_W'(e_sum - (EXP_W+2)'(EXP_BIAS));
            p_o.fields.man  = man;
        end
    end

endmodule

// ==== verilog/pe_cell.sv ====
module pe_cell (
    input  logic             clk,
    input  logic             reset,
    input  logic             load_i,    // Capture weight
    input  logic             start_i,   // Advance one step
    input  sa_pkg::fp_word_u weight_i,
    input  sa_pkg::fp_word_u west_i,    // Activation in
    input  sa_pkg::fp_word_u north_i,   // Partial sum in
    output sa_pkg::fp_word_u east_o,    // Activation out, one step later
    output sa_pkg::fp_word_u south_o    // north_i + west_i * weight
);
    import sa_pkg::*;

    fp_word_u weight;  // Stationary for the whole job
    fp_word_u prod;
    fp_word_u psum;

    fp_mul u_mul (.a_i(west_i), .b_i(weight), .p_o(prod));
    fp_add u_add (.a_i(north_i), .b_i(prod), .s_o(psum));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            weight  <= '0;
            east_o  <= '0;
            south_o <= '0;
        end else if (load_i) begin      // Load wins over start
            weight  <= weight_i;
            east_o  <= '0;              // Flush leftovers of the previous job
            south_o <= '0;
        end else if (start_i) begin
            east_o  <= west_i;
            south_o <= psum;
        end
    end

endmodule

// ==== verilog/psum_drain.sv ====
module psum_drain #(
    parameter int N = 2                     // Array dimension
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             load_i,
    input  logic             start_i,
    input  sa_pkg::fp_word_u south_i [N],   // Bottom row of the array
    output sa_pkg::fp_word_u c_o [N*N],     // Result, row-major
    output logic             done_o
);
    import sa_pkg::*;

    localparam int LAST  = 3 * N - 1;       // Terminal step
    localparam int CNT_W = $clog2(3 * N);

    logic [CNT_W-1:0] cnt;                  // Compute step since load
    logic             step;                 // One compute step this cycle
    logic             capture;

    assign step    = start_i && !load_i && !done_o;
    assign capture = step && (cnt == CNT_W'(LAST));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cnt    <= '0;
            done_o <= 1'b0;
        end else if (load_i) begin
            cnt    <= '0;                   // New job
            done_o <= 1'b0;
        end else if (capture) begin
            done_o <= 1'b1;                 // Counter parks on LAST
        end else if (step) begin
            cnt    <= cnt + 1'b1;
        end
    end

    // C[m][c] leaves the array at step m+c+N, so column c needs N-1-c steps
    // of delay to line up with the last column, plus N slots for its results
    for (genvar c = 0; c < N; c++) begin : g_col
        localparam int DEPTH = 2 * N - 1 - c;

        fp_word_u dl  [DEPTH];              // dl[0] is the newest
        fp_word_u res [N];                  // Captured column of C

        always_ff @(posedge clk or negedge reset) begin
            if (!reset) begin
                for (int k = 0; k < DEPTH; k++) begin
                    dl[k] <= '0;
                end
                for (int m = 0; m < N; m++) begin
                    res[m] <= '0;
                end
            end else begin
                if (step) begin
                    dl[0] <= south_i[c];
                    for (int k = 1; k < DEPTH; k++) begin
                        dl[k] <= dl[k-1];
                    end
                end
                if (capture) begin
                    for (int m = 0; m < N; m++) begin
                        res[m] <= dl[2*N-2-m-c];  // Older rows sit deeper
                    end
                end
            end
        end

        for (genvar m = 0; m < N; m++) begin : g_row
            assign c_o[m*N+c] = res[m];
        end
    end

endmodule

// ==== verilog/sa_pkg.sv ====
package sa_pkg;

    // Word format, bfloat16 style
    localparam int DATA_W   = 16;   // Bits in one word
    localparam int EXP_W    = 8;    // Exponent field
    localparam int MAN_W    = 7;    // Stored mantissa, hidden bit implied
    localparam int EXP_BIAS = 127;  // Exponent bias
    localparam int EXP_MAX  = 254;  // Largest finite result exponent

    // One word seen two ways.
    // The raw view serves magnitude compare, zero test and storage,
    // and the fields view serves decoding.
    typedef union packed {
        logic [DATA_W-1:0] raw;     // Plain bit vector
        struct packed {
            logic             sign; // 1 = negative
            logic [EXP_W-1:0] exp;  // Biased exponent
            logic [MAN_W-1:0] man;  // Fraction, truncated
        } fields;
    } fp_word_u;

endpackage

// ==== verilog/systolic_mm_top.sv ====
module systolic_mm_top #(
    parameter int N = 2                     // Array dimension
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             load_i,        // One-cycle pulse, captures A and B
    input  logic             start_i,       // Compute while high
    input  sa_pkg::fp_word_u a_i [N*N],     // Row-major
    input  sa_pkg::fp_word_u b_i [N*N],     // Row-major, becomes the weights
    output sa_pkg::fp_word_u c_o [N*N],     // A x B, row-major
    output logic             done_o         // High from step 3N-1 until next load
);
    import sa_pkg::*;

    // Activations by column, act[c][r] enters cell (r,c) from the west
    fp_word_u act  [N+1][N];
    // Partial sums by row, psum[r][c] enters cell (r,c) from the north
    fp_word_u psum [N+1][N];

    act_skew_feeder #(.N(N)) u_feeder (
        .clk     (clk),
        .reset   (reset),
        .load_i  (load_i),
        .start_i (start_i),
        .a_i     (a_i),
        .west_o  (act[0])
    );

    for (genvar c = 0; c < N; c++) begin : g_top
        assign psum[0][c] = '0;             // Top row starts from zero
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            pe_cell u_cell (
                .clk      (clk),
                .reset    (reset),
                .load_i   (load_i),
                .start_i  (start_i),
                .weight_i (b_i[r*N+c]),     // B[r][c]
                .west_i   (act[c][r]),
                .north_i  (psum[r][c]),
                .east_o   (act[c+1][r]),
                .south_o  (psum[r+1][c])
            );
        end
    end

    psum_drain #(.N(N)) u_drain (
        .clk     (clk),
        .reset   (reset),
        .load_i  (load_i),
        .start_i (start_i),
        .south_i (psum[N]),
        .c_o     (c_o),
        .done_o  (done_o)
    );

endmodule
